// File: hdl/cdd_macros.svh
/*
 * CD link frame and timing constants, DDR region bases for the
 * memory mapper, PS/2 codes of the debug hotkeys
 */

`ifndef CDD_MACROS_SVH
`define CDD_MACROS_SVH

//////////////////////////////////////////////////
// CD drive serial link
//////////////////////////////////////////////////

// bytes per frame, both directions
`define CDD_FRAME_BYTES 12
// cycles of start level before the transfer begins
`define CDD_START_WAIT 15
// byte done to next request
`define CDD_NEXT_DELAY 1023

//////////////////////////////////////////////////
// DDR upper address bits per region
//////////////////////////////////////////////////

`define DDR_BASE_ROM 9'h000
`define DDR_BASE_SRAM 12'h008
`define DDR_BASE_RAML 8'h01
`define DDR_BASE_RAMH 8'h02

// PS/2 set 2 codes, bit 8 is the extended prefix
`define KEY_F1 9'h005
`define KEY_F2 9'h006
`define KEY_F3 9'h004
`define KEY_F4 9'h00C
`define KEY_F5 9'h003
`define KEY_F6 9'h00B
`define KEY_F9 9'h001
`define KEY_F10 9'h009
`define KEY_PAUSE 9'h177

`endif

// File: hdl/cdd_link_pkg.sv
/*
 * shared types: CD link bytes and frames, memory bus, download
 * stream, DDR request and PS/2 key event
 */

`include "cdd_macros.svh"

package cdd_link_pkg;

	typedef logic [7:0] cdd_byte_t;

	// byte 0 sits in the lowest bits
	typedef struct packed {
		logic toggle;
		cdd_byte_t [`CDD_FRAME_BYTES-1:0] data;
	} cdd_frame_t;

	// all selects active low
	typedef struct packed {
		logic rom_n;
		logic sram_n;
		logic raml_n;
		logic ramh_n;
	} mem_cs_t;

	typedef struct packed {
		logic [24:0] addr;
		logic [31:0] wdata;
		logic [3:0]  dqm_n;
		logic        rd_n;
		mem_cs_t     cs;
	} mem_bus_t;

	// cartridge download stream
	typedef struct packed {
		logic        active;
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;
	} dl_bus_t;

	typedef struct packed {
		logic [26:0] addr;
		logic [31:0] wdata;
		logic        rd;
		logic [3:0]  we;
		logic [1:0]  chan;
		logic        is16;
	} ddr_req_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

endpackage

// File: hdl/cdd_bit_shift.sv
/*
 * CD link bit shifter: comclk edge detect, status bits out on
 * falling edges, host bits in on rising edges
 */

`timescale 1ns/10ps

module cdd_bit_shift (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    load,
	input  cdd_link_pkg::cdd_byte_t load_byte,
	input  logic                    restart,
	input  logic                    cd_comclk,
	input  logic                    cd_hdata,
	output logic                    cd_cdata,
	output cdd_link_pkg::cdd_byte_t rx_byte,
	output logic                    bit_edge,
	output logic                    byte_done
);
	import cdd_link_pkg::*;

	cdd_byte_t  tx_shift;
	logic       comclk_q;
	logic       rise;
	logic       fall;
	logic [2:0] bit_cnt;

	// single sampling stage, also follows the line during reset
	always_ff @(posedge clk_sys) begin
		comclk_q <= cd_comclk;
	end

	assign rise = cd_comclk & ~comclk_q;
	assign fall = ~cd_comclk & comclk_q;
	assign bit_edge = rise;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bit_cnt <= '0;
			byte_done <= 1'b0;
			cd_cdata <= 1'b0;
		end else begin
			if (fall) begin
				cd_cdata <= tx_shift[0];
			end
			if (restart) begin
				bit_cnt <= '0;
			end else if (rise) begin
				bit_cnt <= bit_cnt + 3'd1;
			end
			// eighth rising edge closes the byte
			byte_done <= rise && !restart && (bit_cnt == 3'd7);
		end
	end

	// lsb first both ways
	always_ff @(posedge clk_sys) begin
		if (load) begin
			tx_shift <= load_byte;
		end else if (fall) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end
		if (rise) begin
			rx_byte <= {cd_hdata, rx_byte[7:1]};
		end
	end

endmodule

// File: hdl/cdd_byte_seq.sv
/*
 * CD link byte sequencer: status byte selection, host byte store,
 * sync and request lines with inter-byte delay
 */

`timescale 1ns/10ps

`include "cdd_macros.svh"

module cdd_byte_seq (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  cdd_link_pkg::cdd_frame_t status,
	input  logic                     begin_xfer,
	input  logic                     cd_comclk,
	input  logic                     cd_hdata,
	output logic                     cd_cdata,
	output logic                     cd_comreq_n,
	output logic                     cd_comsync_n,
	output cdd_link_pkg::cdd_frame_t host_frame,
	output logic                     comm_rdy
);
	import cdd_link_pkg::*;

	cdd_byte_t  load_byte;
	cdd_byte_t  rx_byte;
	logic       load;
	logic       bit_edge;
	logic       byte_done;
	logic [3:0] byte_cnt;
	logic [9:0] next_delay;
	logic       trans_next;
	logic       in_frame;
	logic       last_byte;

	assign in_frame = byte_cnt < 4'(`CDD_FRAME_BYTES);
	assign last_byte = byte_cnt == 4'(`CDD_FRAME_BYTES - 1);
	assign load = begin_xfer | byte_done;

	// next byte for the shifter, zero once the frame is out
	always_comb begin
		if (begin_xfer) begin
			load_byte = status.data[0];
		end else if (last_byte || !in_frame) begin
			load_byte = '0;
		end else begin
			load_byte = status.data[byte_cnt + 4'd1];
		end
	end

	cdd_bit_shift bit_shift_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.load      (load),
		.load_byte (load_byte),
		.restart   (begin_xfer),
		.cd_comclk (cd_comclk),
		.cd_hdata  (cd_hdata),
		.cd_cdata  (cd_cdata),
		.rx_byte   (rx_byte),
		.bit_edge  (bit_edge),
		.byte_done (byte_done)
	);

	//////////////////////////////////////////////////
	// byte count, sync and request
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			byte_cnt <= '0;
			next_delay <= '0;
			trans_next <= 1'b0;
			comm_rdy <= 1'b0;
			cd_comsync_n <= 1'b1;
			cd_comreq_n <= 1'b1;
		end else begin
			trans_next <= 1'b0;
			comm_rdy <= 1'b0;
			if (begin_xfer) begin
				byte_cnt <= '0;
				next_delay <= '0;
				cd_comsync_n <= 1'b0;
				trans_next <= 1'b1;
			end else if (byte_done) begin
				cd_comsync_n <= 1'b1;
				next_delay <= 10'(`CDD_NEXT_DELAY);
				if (in_frame) begin
					byte_cnt <= byte_cnt + 4'd1;
				end
				comm_rdy <= last_byte;
			end else if (next_delay != '0) begin
				next_delay <= next_delay - 10'd1;
				trans_next <= next_delay == 10'd1;
			end

			// request drops when a byte is ready, rises on each bit
			if (trans_next) begin
				cd_comreq_n <= 1'b0;
			end else if (bit_edge) begin
				cd_comreq_n <= 1'b1;
			end
		end
	end

	// received command bytes
	always_ff @(posedge clk_sys) begin
		if (begin_xfer) begin
			host_frame.toggle <= status.toggle;
		end
		if (byte_done && in_frame) begin
			host_frame.data[byte_cnt] <= rx_byte;
		end
	end

endmodule

// File: hdl/cdd_frame_sync.sv
/*
 * status frame latch on toggle change, start countdown with
 * begin pulse, command frame publish with flipped toggle
 */

`timescale 1ns/10ps

`include "cdd_macros.svh"

module cdd_frame_sync (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  cdd_link_pkg::cdd_frame_t cd_out,
	output cdd_link_pkg::cdd_frame_t cd_in,
	output cdd_link_pkg::cdd_frame_t status,
	output logic                     begin_xfer,
	input  cdd_link_pkg::cdd_frame_t host_frame,
	input  logic                     comm_rdy
);

	logic       last_toggle;
	logic       start_lvl;
	logic [3:0] wait_cnt;
	logic       new_frame;

	assign new_frame = cd_out.toggle != last_toggle;

	// start level, then begin once the countdown has run out
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// track the line so no frame is seen coming out of reset
			last_toggle <= cd_out.toggle;
			start_lvl <= 1'b0;
			wait_cnt <= '0;
		end else if (new_frame) begin
			last_toggle <= cd_out.toggle;
			start_lvl <= 1'b1;
			wait_cnt <= 4'(`CDD_START_WAIT);
		end else if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - 4'd1;
		end else begin
			start_lvl <= 1'b0;
		end
	end

	assign begin_xfer = start_lvl && (wait_cnt == '0);

	// drive status bytes
	always_ff @(posedge clk_sys) begin
		if (new_frame) begin
			status <= cd_out;
		end
	end

	// host command frame back to the drive side
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cd_in <= '0;
		end else if (comm_rdy) begin
			cd_in.data <= host_frame.data;
			cd_in.toggle <= ~cd_in.toggle;
		end
	end

endmodule

// File: hdl/mem_chan_map.sv
/*
 * chip-select decode onto one DDR request, cartridge download mux,
 * memory wait and download back-pressure
 */

`timescale 1ns/10ps

`include "cdd_macros.svh"

module mem_chan_map (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cdd_link_pkg::mem_bus_t mem,
	input  cdd_link_pkg::dl_bus_t  dl,
	input  logic                   ddr_busy,
	output cdd_link_pkg::ddr_req_t ddr,
	output logic                   mem_wait_n,
	output logic                   ioctl_wait
);

	logic        busy_q;
	logic [1:0]  chan;
	logic [26:0] map_addr;
	logic        any_cs;
	logic        ram_wr;

	// priority rom, sram, raml, ramh
	always_comb begin
		if (!mem.cs.rom_n) begin
			chan = 2'd0;
			map_addr = {`DDR_BASE_ROM, mem.addr[18:1]};
		end else if (!mem.cs.sram_n) begin
			chan = 2'd1;
			map_addr = {`DDR_BASE_SRAM, mem.addr[15:1]};
		end else if (!mem.cs.raml_n) begin
			chan = 2'd2;
			map_addr = {`DDR_BASE_RAML, mem.addr[19:1]};
		end else begin
			// high work RAM is 32 bits wide
			chan = 2'd3;
			map_addr = {`DDR_BASE_RAMH, mem.addr[19:2], 1'b0};
		end
	end

	assign any_cs = ~&mem.cs;
	// rom is never written
	assign ram_wr = ~(mem.cs.sram_n & mem.cs.raml_n & mem.cs.ramh_n);

	always_comb begin
		if (dl.active) begin
			ddr.addr = {3'b000, dl.addr[24:1]};
			ddr.wdata = {16'h0000, dl.data[7:0], dl.data[15:8]};
			ddr.rd = 1'b0;
			ddr.we = {2'b00, {2{ioctl_wait}}};
			ddr.chan = 2'd0;
			ddr.is16 = 1'b1;
		end else begin
			ddr.addr = map_addr;
			ddr.wdata = mem.wdata;
			ddr.rd = any_cs & ~mem.rd_n;
			ddr.we = {4{ram_wr}} & ~mem.dqm_n;
			ddr.chan = chan;
			ddr.is16 = mem.cs.ramh_n;
		end
	end

	assign mem_wait_n = ~ddr_busy;

	// hold the download until the DDR side goes idle again
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy_q <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			busy_q <= ddr_busy;
			if (busy_q && !ddr_busy) begin
				ioctl_wait <= 1'b0;
			end else if (dl.active && dl.wr) begin
				ioctl_wait <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/debug_hotkeys.sv
/*
 * debug hotkeys: layer, sound and pause enables from PS/2 events
 */

`timescale 1ns/10ps

`include "cdd_macros.svh"

module debug_hotkeys (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cdd_link_pkg::ps2_key_t ps2_key,
	output logic [5:0]             scrn_en,
	output logic [1:0]             snd_en,
	output logic                   pause_en
);

	logic last_toggle;
	logic key_down;

	// new event with the key pressed
	assign key_down = (ps2_key.toggle != last_toggle) && ps2_key.pressed;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_toggle <= ps2_key.toggle;
			scrn_en <= '1;
			snd_en <= '1;
			pause_en <= 1'b0;
		end else begin
			last_toggle <= ps2_key.toggle;
			if (key_down) begin
				case (ps2_key.code)
					`KEY_F1: scrn_en[0] <= ~scrn_en[0];
					`KEY_F2: scrn_en[1] <= ~scrn_en[1];
					`KEY_F3: scrn_en[2] <= ~scrn_en[2];
					`KEY_F4: scrn_en[3] <= ~scrn_en[3];
					`KEY_F5: scrn_en[4] <= ~scrn_en[4];
					`KEY_F6: scrn_en[5] <= ~scrn_en[5];
					// sound channels
					`KEY_F9: snd_en[0] <= ~snd_en[0];
					`KEY_F10: snd_en[1] <= ~snd_en[1];
					`KEY_PAUSE: pause_en <= ~pause_en;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: hdl/cdd_link_top.sv
/*
 * top level: CD drive serial link, cartridge/work RAM mapper
 * and debug hotkeys
 */

`timescale 1ns/10ps

module cdd_link_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  cdd_link_pkg::cdd_frame_t cd_out,
	output cdd_link_pkg::cdd_frame_t cd_in,
	input  logic                     cd_comclk,
	input  logic                     cd_hdata,
	output logic                     cd_cdata,
	output logic                     cd_comreq_n,
	output logic                     cd_comsync_n,
	input  cdd_link_pkg::mem_bus_t   mem,
	input  cdd_link_pkg::dl_bus_t    dl,
	input  logic                     ddr_busy,
	output cdd_link_pkg::ddr_req_t   ddr,
	output logic                     mem_wait_n,
	output logic                     ioctl_wait,
	input  cdd_link_pkg::ps2_key_t   ps2_key,
	output logic [5:0]               scrn_en,
	output logic [1:0]               snd_en,
	output logic                     pause_en
);
	import cdd_link_pkg::*;

	cdd_frame_t status;
	cdd_frame_t host_frame;
	logic       begin_xfer;
	logic       comm_rdy;

	//////////////////////////////////////////////////
	// CD drive link
	//////////////////////////////////////////////////

	cdd_frame_sync frame_sync_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cd_out     (cd_out),
		.cd_in      (cd_in),
		.status     (status),
		.begin_xfer (begin_xfer),
		.host_frame (host_frame),
		.comm_rdy   (comm_rdy)
	);

	cdd_byte_seq byte_seq_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.status       (status),
		.begin_xfer   (begin_xfer),
		.cd_comclk    (cd_comclk),
		.cd_hdata     (cd_hdata),
		.cd_cdata     (cd_cdata),
		.cd_comreq_n  (cd_comreq_n),
		.cd_comsync_n (cd_comsync_n),
		.host_frame   (host_frame),
		.comm_rdy     (comm_rdy)
	);

	//////////////////////////////////////////////////
	// memory and debug
	//////////////////////////////////////////////////

	mem_chan_map mem_map_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mem        (mem),
		.dl         (dl),
		.ddr_busy   (ddr_busy),
		.ddr        (ddr),
		.mem_wait_n (mem_wait_n),
		.ioctl_wait (ioctl_wait)
	);

	debug_hotkeys hotkeys_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ps2_key  (ps2_key),
		.scrn_en  (scrn_en),
		.snd_en   (snd_en),
		.pause_en (pause_en)
	);

endmodule

// File: verif/cdd_link_props.sv
/*
 * concurrent assertions on the CD link sync, request and ready
 * lines, bound into the byte sequencer
 */

`timescale 1ns/10ps

module cdd_link_props (
	input logic clk_sys,
	input logic reset,
	input logic cd_comclk,
	input logic cd_comreq_n,
	input logic cd_comsync_n,
	input logic comm_rdy
);

	// assertion failures so far
	int fail_cnt = 0;

	// sync line idle through reset
	sync_idle_in_reset: assert property (@(posedge clk_sys) reset |=> cd_comsync_n)
		else begin
			fail_cnt++;
			$error("cd_comsync_n low while reset is asserted");
		end

	// frame ready is a strobe
	rdy_single_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		comm_rdy |=> !comm_rdy)
		else begin
			fail_cnt++;
			$error("comm_rdy held longer than one cycle");
		end

	// every host bit acknowledged on the request line
	req_rise_on_bit: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(cd_comclk) |=> cd_comreq_n)
		else begin
			fail_cnt++;
			$error("cd_comreq_n did not rise after a cd_comclk rising edge");
		end

endmodule

bind cdd_byte_seq cdd_link_props props_i (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.cd_comclk    (cd_comclk),
	.cd_comreq_n  (cd_comreq_n),
	.cd_comsync_n (cd_comsync_n),
	.comm_rdy     (comm_rdy)
);

// File: verif/cdd_link_tb.sv
/*
 * testbench for the CD link top level: reset values, two full CD
 * exchanges, memory mapping, download back-pressure, debug hotkeys
 */

`timescale 1ns/10ps

`include "cdd_macros.svh"

module cdd_link_tb;
	import cdd_link_pkg::*;

	// twenty frames of thirteen byte slots, each a bit over the inter-byte delay
	localparam int TIMEOUT_CYCLES = 20 * 13 * 1100;

	logic       clk_sys = 1'b0;
	logic       reset;
	cdd_frame_t cd_out;
	cdd_frame_t cd_in;
	logic       cd_comclk;
	logic       cd_hdata;
	logic       cd_cdata;
	logic       cd_comreq_n;
	logic       cd_comsync_n;
	mem_bus_t   mem;
	dl_bus_t    dl;
	logic       ddr_busy;
	ddr_req_t   ddr;
	logic       mem_wait_n;
	logic       ioctl_wait;
	ps2_key_t   ps2_key;
	logic [5:0] scrn_en;
	logic [1:0] snd_en;
	logic       pause_en;

	integer seed;
	int     err_cnt = 0;
	int     check_cnt = 0;
	int     cycle_cnt = 0;
	string  test_name = "none";
	// toggle that cd_in should carry after the next exchange
	logic   in_toggle_exp = 1'b0;

	cdd_link_top dut_i (.*);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout in %s, the run did not finish within %0d cycles",
				test_name, TIMEOUT_CYCLES);
			$display("checks %0d, errors %0d", check_cnt, err_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_frame(input string what, input cdd_frame_t exp, input cdd_frame_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_byte(input string what, input cdd_byte_t exp, input cdd_byte_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_ddr(input string what, input ddr_req_t exp, input ddr_req_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_bits(input string what, input logic [8:0] exp, input logic [8:0] act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	// inputs change just after the rising edge
	task automatic step_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic reset_values;
		test_name = "reset_values";
		check_bits("link lines", 9'b1100, {5'b0, cd_comreq_n, cd_comsync_n, cd_cdata, ioctl_wait});
		check_frame("cd_in", '0, cd_in);
		check_bits("enables", 9'h0FF, {pause_en, snd_en, scrn_en});
	endtask

	// acts as the CD block for one status frame and one command frame
	task automatic cd_exchange;
		cdd_frame_t frame;
		cdd_frame_t host_exp;
		cdd_byte_t  seen;
		int         b;
		int         k;
		test_name = "cd_exchange";
		frame.toggle = ~cd_out.toggle;
		for (b = 0; b < `CDD_FRAME_BYTES; b++) begin
			frame.data[b] = $random(seed);
			host_exp.data[b] = $random(seed);
		end
		in_toggle_exp = ~in_toggle_exp;
		host_exp.toggle = in_toggle_exp;
		cd_out = frame;
		for (b = 0; b < `CDD_FRAME_BYTES; b++) begin
			if (b == 0) begin
				while (cd_comsync_n !== 1'b0) step_cycle();
			end
			while (cd_comreq_n !== 1'b0) step_cycle();
			for (k = 0; k < 8; k++) begin
				cd_comclk = 1'b0;
				step_cycle();
				step_cycle();
				seen[k] = cd_cdata;
				cd_hdata = host_exp.data[b][k];
				cd_comclk = 1'b1;
				step_cycle();
				step_cycle();
			end
			check_byte($sformatf("status byte %0d", b), frame.data[b], seen);
		end
		while (cd_in.toggle !== in_toggle_exp) step_cycle();
		check_frame("cd_in", host_exp, cd_in);
	endtask

	// rule table of the mapper, ch is the selected region
	function automatic ddr_req_t map_expect(input mem_bus_t m, input int ch);
		ddr_req_t r;
		r.wdata = m.wdata;
		r.rd = ~m.rd_n;
		r.chan = 2'(ch);
		// byte writes and width follow the raw selects, not the priority
		r.is16 = 1'b1;
		if (!m.cs.ramh_n) begin
			r.is16 = 1'b0;
		end
		r.we = 4'h0;
		if (!m.cs.sram_n || !m.cs.raml_n || !m.cs.ramh_n) begin
			r.we = ~m.dqm_n;
		end
		case (ch)
			0: r.addr = {`DDR_BASE_ROM, m.addr[18:1]};
			1: r.addr = {`DDR_BASE_SRAM, m.addr[15:1]};
			2: r.addr = {`DDR_BASE_RAML, m.addr[19:1]};
			default: r.addr = {`DDR_BASE_RAMH, m.addr[19:2], 1'b0};
		endcase
		return r;
	endfunction

	task automatic mem_mapping;
		logic [3:0] cs_vec;
		int         ch;
		int         n;
		int         j;
		test_name = "mem_mapping";
		for (ch = 0; ch < 4; ch++) begin
			for (n = 0; n < 8; n++) begin
				// higher priority selects idle, lower ones random
				cs_vec = $random(seed);
				for (j = 0; j < ch; j++) begin
					cs_vec[3-j] = 1'b1;
				end
				cs_vec[3-ch] = 1'b0;
				mem.addr = $random(seed);
				mem.wdata = $random(seed);
				mem.dqm_n = $random(seed);
				mem.rd_n = $random(seed);
				mem.cs = cs_vec;
				ddr_busy = $random(seed);
				#10;
				check_ddr($sformatf("chan %0d", ch), map_expect(mem, ch), ddr);
				check_bits("mem_wait_n", {8'b0, ~ddr_busy}, {8'b0, mem_wait_n});
				step_cycle();
			end
		end
		mem = '{addr: '0, wdata: '0, dqm_n: 4'hF, rd_n: 1'b1, cs: 4'hF};
		ddr_busy = 1'b0;
		step_cycle();
	endtask

	task automatic download_path;
		ddr_req_t exp;
		test_name = "download_path";
		dl.active = 1'b1;
		dl.wr = 1'b1;
		dl.addr = $random(seed);
		dl.data = $random(seed);
		// word address, bytes swapped in the low half
		exp.addr = 27'(dl.addr) >> 1;
		exp.wdata = '0;
		exp.wdata[15:8] = dl.data[7:0];
		exp.wdata[7:0] = dl.data[15:8];
		exp.rd = 1'b0;
		exp.we = 4'h0;
		exp.chan = 2'd0;
		exp.is16 = 1'b1;
		#10;
		check_ddr("write", exp, ddr);
		step_cycle();
		dl.wr = 1'b0;
		ddr_busy = 1'b1;
		exp.we = 4'h3;
		check_bits("wait set", 9'd1, {8'b0, ioctl_wait});
		check_ddr("waiting", exp, ddr);
		repeat (3) step_cycle();
		check_bits("wait held", 9'd1, {8'b0, ioctl_wait});
		ddr_busy = 1'b0;
		#10;
		check_bits("wait before clear", 9'd1, {8'b0, ioctl_wait});
		step_cycle();
		check_bits("wait cleared", 9'd0, {8'b0, ioctl_wait});
		dl = '0;
		step_cycle();
	endtask

	// one event, visible one cycle later
	task automatic send_key(input logic [8:0] code, input logic pressed);
		ps2_key.toggle = ~ps2_key.toggle;
		ps2_key.pressed = pressed;
		ps2_key.code = code;
		step_cycle();
	endtask

	task automatic hotkey_toggles;
		logic [8:0] codes [9];
		logic [8:0] exp_en;
		int         i;
		test_name = "hotkey_toggles";
		codes = '{`KEY_F1, `KEY_F2, `KEY_F3, `KEY_F4, `KEY_F5, `KEY_F6,
			`KEY_F9, `KEY_F10, `KEY_PAUSE};
		exp_en = 9'h0FF;
		for (i = 0; i < 9; i++) begin
			send_key(codes[i], 1'b1);
			exp_en[i] = ~exp_en[i];
			check_bits($sformatf("key %0d", i), exp_en, {pause_en, snd_en, scrn_en});
		end
		send_key(`KEY_F1, 1'b0);
		check_bits("release", exp_en, {pause_en, snd_en, scrn_en});
		send_key(9'h01C, 1'b1);
		check_bits("unlisted code", exp_en, {pause_en, snd_en, scrn_en});
		// same event toggle, new code
		ps2_key.code = `KEY_F2;
		step_cycle();
		step_cycle();
		check_bits("no event", exp_en, {pause_en, snd_en, scrn_en});
		send_key(`KEY_PAUSE, 1'b1);
		exp_en[8] = ~exp_en[8];
		check_bits("pause again", exp_en, {pause_en, snd_en, scrn_en});
	endtask

	initial begin
		seed = 18389;
		reset = 1'b1;
		cd_out = '0;
		cd_comclk = 1'b1;
		cd_hdata = 1'b0;
		mem = '{addr: '0, wdata: '0, dqm_n: 4'hF, rd_n: 1'b1, cs: 4'hF};
		dl = '0;
		ddr_busy = 1'b0;
		ps2_key = '0;
		repeat (4) step_cycle();
		reset = 1'b0;
		reset_values();
		cd_exchange();
		cd_exchange();
		mem_mapping();
		download_path();
		hotkey_toggles();
		$display("checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt,
			dut_i.byte_seq_i.props_i.fail_cnt);
		if (err_cnt == 0 && dut_i.byte_seq_i.props_i.fail_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+hdl
hdl/cdd_link_pkg.sv
hdl/cdd_bit_shift.sv
hdl/cdd_byte_seq.sv
hdl/cdd_frame_sync.sv
hdl/mem_chan_map.sv
hdl/debug_hotkeys.sv
hdl/cdd_link_top.sv
verif/cdd_link_props.sv
verif/cdd_link_tb.sv

// File: Bender.yml
package:
  name: cdd_link

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cdd_link_pkg.sv
      - hdl/cdd_bit_shift.sv
      - hdl/cdd_byte_seq.sv
      - hdl/cdd_frame_sync.sv
      - hdl/mem_chan_map.sv
      - hdl/debug_hotkeys.sv
      - hdl/cdd_link_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/cdd_link_props.sv
      - verif/cdd_link_tb.sv
